// ==== verilog/vr_log_pkg.sv ====
package vr_log_pkg;

    // Circular log geometry. LOG_DEPTH must stay a power of two.
    localparam int LOG_DEPTH   = 16;
    localparam int LOG_DEPTH_W = 4;

    // Operation, view-local commit numbers and entry payloads.
    localparam int OP_W    = 16;
    localparam int ENTRY_W = 32;    // Also the width of the commit checksum.

endpackage

// ==== verilog/vr_msg_pkg.sv ====
package vr_msg_pkg;

    localparam int MSG_W  = 64;
    localparam int TYPE_W = 2;
    localparam int VIEW_W = 14;

    // Message type codes.
    localparam logic [TYPE_W-1:0] MSG_SETUP   = 2'd0;
    localparam logic [TYPE_W-1:0] MSG_PREPARE = 2'd1;
    localparam logic [TYPE_W-1:0] MSG_COMMIT  = 2'd2;

    // Reply kind codes.
    localparam logic [TYPE_W-1:0] RPL_SETUP_ACK   = 2'd0;
    localparam logic [TYPE_W-1:0] RPL_PREPARE_OK  = 2'd1;
    localparam logic [TYPE_W-1:0] RPL_COMMIT_DONE = 2'd2;
    localparam logic [TYPE_W-1:0] RPL_NACK        = 2'd3;

    // The reply word holds kind, view, num and data with kind in the top bits.
    localparam int RPL_DATA_LSB = 0;
    localparam int RPL_NUM_LSB  = RPL_DATA_LSB + vr_log_pkg::ENTRY_W;
    localparam int RPL_VIEW_LSB = RPL_NUM_LSB + vr_log_pkg::OP_W;
    localparam int RPL_KIND_LSB = RPL_VIEW_LSB + VIEW_W;

    typedef struct packed {
        logic [TYPE_W-1:0]              msg_type;
        logic [VIEW_W-1:0]              view;
        logic [vr_log_pkg::OP_W-1:0]    op_num;
        logic [vr_log_pkg::ENTRY_W-1:0] entry;
    } vr_prep_hdr_t;

    typedef struct packed {
        logic [TYPE_W-1:0]              msg_type;
        logic [VIEW_W-1:0]              view;
        logic [vr_log_pkg::OP_W-1:0]    commit_num;
        logic [vr_log_pkg::ENTRY_W-1:0] rsvd;
    } vr_commit_hdr_t;

    // SETUP words are read through the prepare view and only use type and view.
    typedef union packed {
        vr_prep_hdr_t   prepare;
        vr_commit_hdr_t commit;
    } vr_msg_u;

endpackage

// ==== verilog/vr_ctrl.sv ====
`timescale 1ns/10ps

module vr_ctrl (
     input  logic                                clk
    ,input  logic                                rst_n

    ,input  logic                                in_val
    ,input  vr_msg_pkg::vr_msg_u                 in_msg
    ,output logic                                in_rdy

    ,output logic                                wr_en
    ,output logic [vr_log_pkg::LOG_DEPTH_W-1:0]  wr_addr
    ,output logic [vr_log_pkg::ENTRY_W-1:0]      wr_data

    ,output logic                                walk_start
    ,output logic [vr_log_pkg::LOG_DEPTH_W-1:0]  walk_first
    ,output logic [vr_log_pkg::OP_W-1:0]         walk_count
    ,input  logic                                walk_done
    ,input  logic [vr_log_pkg::ENTRY_W-1:0]      walk_sum

    ,output logic                                push
    ,output logic [vr_msg_pkg::TYPE_W-1:0]       rpl_kind
    ,output logic [vr_msg_pkg::VIEW_W-1:0]       rpl_view
    ,output logic [vr_log_pkg::OP_W-1:0]         rpl_num
    ,output logic [vr_log_pkg::ENTRY_W-1:0]      rpl_data
    ,input  logic                                full
);

    logic                               active;
    logic                               st_decide;
    logic                               st_walk;
    logic                               st_push;
    logic                               idle;
    logic                               accept;

    vr_msg_pkg::vr_msg_u                msg_q;

    logic [vr_msg_pkg::VIEW_W-1:0]      view;
    logic [vr_log_pkg::OP_W-1:0]        op_num;
    logic [vr_log_pkg::OP_W-1:0]        last_commit;
    logic [vr_log_pkg::OP_W-1:0]        next_op;
    logic [vr_log_pkg::OP_W-1:0]        first_op;
    logic [vr_log_pkg::OP_W-1:0]        occupancy;

    logic                               is_setup;
    logic                               prep_ok;
    logic                               commit_ok;

    logic [vr_msg_pkg::TYPE_W-1:0]      d_kind;
    logic [vr_msg_pkg::VIEW_W-1:0]      d_view;
    logic [vr_log_pkg::OP_W-1:0]        d_num;
    logic [vr_log_pkg::ENTRY_W-1:0]     d_data;

    logic [vr_msg_pkg::TYPE_W-1:0]      kind_q;
    logic [vr_msg_pkg::VIEW_W-1:0]      view_q;
    logic [vr_log_pkg::OP_W-1:0]        num_q;
    logic [vr_log_pkg::ENTRY_W-1:0]     data_q;

    assign idle   = active && !(st_decide || st_walk || st_push);
    assign in_rdy = idle && !full;
    assign accept = in_val && in_rdy;

    assign next_op   = op_num + 1'b1;
    assign first_op  = last_commit + 1'b1;
    assign occupancy = op_num - last_commit;

    assign is_setup  = msg_q.prepare.msg_type == vr_msg_pkg::MSG_SETUP;

    // The log still has a free slot when fewer than LOG_DEPTH entries are uncommitted.
    assign prep_ok = (msg_q.prepare.msg_type == vr_msg_pkg::MSG_PREPARE)
                  && (msg_q.prepare.view == view)
                  && (msg_q.prepare.op_num == next_op)
                  && (occupancy[vr_log_pkg::OP_W-1:vr_log_pkg::LOG_DEPTH_W] == '0);

    assign commit_ok = (msg_q.commit.msg_type == vr_msg_pkg::MSG_COMMIT)
                    && (msg_q.commit.view == view)
                    && (msg_q.commit.commit_num > last_commit)
                    && (msg_q.commit.commit_num <= op_num);

    // Reply for everything decided in one step; a NACK unless proven otherwise.
    always_comb begin
        d_kind = vr_msg_pkg::RPL_NACK;
        d_view = view;
        d_num  = op_num;
        d_data = '0;
        if (is_setup) begin
            d_kind = vr_msg_pkg::RPL_SETUP_ACK;
            d_view = msg_q.prepare.view;
            d_num  = '0;
        end else if (prep_ok) begin
            d_kind = vr_msg_pkg::RPL_PREPARE_OK;
            d_num  = msg_q.prepare.op_num;
        end
    end

    assign wr_en   = st_decide && prep_ok;
    assign wr_addr = msg_q.prepare.op_num[vr_log_pkg::LOG_DEPTH_W-1:0];
    assign wr_data = msg_q.prepare.entry;

    assign walk_start = st_decide && commit_ok;
    assign walk_first = first_op[vr_log_pkg::LOG_DEPTH_W-1:0];
    assign walk_count = msg_q.commit.commit_num - last_commit;

    assign push     = !full && ((st_decide && !commit_ok) || st_push);
    assign rpl_kind = st_push ? kind_q : d_kind;
    assign rpl_view = st_push ? view_q : d_view;
    assign rpl_num  = st_push ? num_q  : d_num;
    assign rpl_data = st_push ? data_q : d_data;

    always_ff @(posedge clk) begin
        if (accept) begin
            msg_q <= in_msg;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active      <= 1'b0;
            st_decide   <= 1'b0;
            st_walk     <= 1'b0;
            st_push     <= 1'b0;
            view        <= '0;
            op_num      <= '0;
            last_commit <= '0;
        end else begin
            active <= 1'b1;
            if (accept) begin
                st_decide <= 1'b1;
            end
            if (st_decide) begin
                st_decide <= 1'b0;
                if (is_setup) begin
                    view        <= msg_q.prepare.view;
                    op_num      <= '0;
                    last_commit <= '0;
                end
                if (prep_ok) begin
                    op_num <= next_op;
                end
                if (commit_ok) begin
                    last_commit <= msg_q.commit.commit_num;
                    st_walk     <= 1'b1;
                end else if (full) begin
                    st_push <= 1'b1;   // Hold the reply until a queue slot frees.
                end
            end
            if (st_walk && walk_done) begin
                st_walk <= 1'b0;
                st_push <= 1'b1;
            end
            if (st_push && !full) begin
                st_push <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (st_decide && !commit_ok && full) begin
            kind_q <= d_kind;
            view_q <= d_view;
            num_q  <= d_num;
            data_q <= d_data;
        end
        if (st_walk && walk_done) begin
            kind_q <= vr_msg_pkg::RPL_COMMIT_DONE;
            view_q <= view;
            num_q  <= msg_q.commit.commit_num;
            data_q <= walk_sum;
        end
    end

endmodule

// ==== verilog/vr_log_mem.sv ====
`timescale 1ns/10ps

module vr_log_mem (
     input  logic                                clk

    ,input  logic                                wr_en
    ,input  logic [vr_log_pkg::LOG_DEPTH_W-1:0]  wr_addr
    ,input  logic [vr_log_pkg::ENTRY_W-1:0]      wr_data

    ,input  logic                                rd_en
    ,input  logic [vr_log_pkg::LOG_DEPTH_W-1:0]  rd_addr
    ,output logic [vr_log_pkg::ENTRY_W-1:0]      rd_data
);

    logic [vr_log_pkg::ENTRY_W-1:0] entries [vr_log_pkg::LOG_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            entries[wr_addr] <= wr_data;
        end
    end

    // Read data is valid on the cycle after rd_en.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= entries[rd_addr];
        end
    end

endmodule

// ==== verilog/vr_commit_walker.sv ====
`timescale 1ns/10ps

module vr_commit_walker (
     input  logic                                clk
    ,input  logic                                rst_n

    ,input  logic                                walk_start
    ,input  logic [vr_log_pkg::LOG_DEPTH_W-1:0]  walk_first
    ,input  logic [vr_log_pkg::OP_W-1:0]         walk_count
    ,output logic                                walk_done
    ,output logic [vr_log_pkg::ENTRY_W-1:0]      walk_sum

    ,output logic                                rd_en
    ,output logic [vr_log_pkg::LOG_DEPTH_W-1:0]  rd_addr
    ,input  logic [vr_log_pkg::ENTRY_W-1:0]      rd_data
);

    logic                               busy;
    logic                               pend;   // A read was issued last cycle.
    logic [vr_log_pkg::OP_W-1:0]        remain;
    logic [vr_log_pkg::ENTRY_W-1:0]     sum;

    assign rd_en     = busy && (remain != '0);
    assign walk_done = busy && (remain == '0);

    // The last entry arrives in the same cycle as walk_done.
    assign walk_sum = pend ? (sum ^ rd_data) : sum;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            pend   <= 1'b0;
            remain <= '0;
        end else begin
            pend <= rd_en;
            if (walk_start) begin
                busy   <= 1'b1;
                remain <= walk_count;
            end else if (walk_done) begin
                busy <= 1'b0;
            end else if (rd_en) begin
                remain <= remain - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (walk_start) begin
            rd_addr <= walk_first;
            sum     <= '0;
        end else begin
            if (rd_en) begin
                rd_addr <= rd_addr + 1'b1;   // Wraps with the circular log.
            end
            if (pend) begin
                sum <= sum ^ rd_data;
            end
        end
    end

endmodule

// ==== verilog/vr_reply_queue.sv ====
`timescale 1ns/10ps

module vr_reply_queue (
     input  logic                                clk
    ,input  logic                                rst_n

    ,input  logic                                push
    ,input  logic [vr_msg_pkg::TYPE_W-1:0]       rpl_kind
    ,input  logic [vr_msg_pkg::VIEW_W-1:0]       rpl_view
    ,input  logic [vr_log_pkg::OP_W-1:0]         rpl_num
    ,input  logic [vr_log_pkg::ENTRY_W-1:0]      rpl_data
    ,output logic                                full

    ,output logic                                out_val
    ,output logic [vr_msg_pkg::MSG_W-1:0]        out_reply
    ,input  logic                                out_rdy
);

    logic [vr_msg_pkg::MSG_W-1:0]   rpl_word;
    logic [vr_msg_pkg::MSG_W-1:0]   slots [2];
    logic                           wr_ptr;
    logic                           rd_ptr;
    logic [1:0]                     count;
    logic                           pop;

    always_comb begin
        rpl_word = '0;
        rpl_word[vr_msg_pkg::RPL_KIND_LSB +: vr_msg_pkg::TYPE_W]  = rpl_kind;
        rpl_word[vr_msg_pkg::RPL_VIEW_LSB +: vr_msg_pkg::VIEW_W]  = rpl_view;
        rpl_word[vr_msg_pkg::RPL_NUM_LSB  +: vr_log_pkg::OP_W]    = rpl_num;
        rpl_word[vr_msg_pkg::RPL_DATA_LSB +: vr_log_pkg::ENTRY_W] = rpl_data;
    end

    assign out_val   = count != 2'd0;
    assign full      = count == 2'd2;
    assign out_reply = slots[rd_ptr];   // Head entry.
    assign pop       = out_val && out_rdy;

    always_ff @(posedge clk) begin
        if (push) begin
            slots[wr_ptr] <= rpl_word;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            case ({push, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== verilog/vr_top.sv ====
`timescale 1ns/10ps

module vr_top (
     input  logic                            clk
    ,input  logic                            rst_n

    ,input  logic                            in_val
    ,input  vr_msg_pkg::vr_msg_u             in_msg
    ,output logic                            in_rdy

    ,output logic                            out_val
    ,output logic [vr_msg_pkg::MSG_W-1:0]    out_reply
    ,input  logic                            out_rdy
);

    logic                                wr_en;
    logic [vr_log_pkg::LOG_DEPTH_W-1:0]  wr_addr;
    logic [vr_log_pkg::ENTRY_W-1:0]      wr_data;

    logic                                rd_en;
    logic [vr_log_pkg::LOG_DEPTH_W-1:0]  rd_addr;
    logic [vr_log_pkg::ENTRY_W-1:0]      rd_data;

    logic                                walk_start;
    logic [vr_log_pkg::LOG_DEPTH_W-1:0]  walk_first;
    logic [vr_log_pkg::OP_W-1:0]         walk_count;
    logic                                walk_done;
    logic [vr_log_pkg::ENTRY_W-1:0]      walk_sum;

    logic                                push;
    logic [vr_msg_pkg::TYPE_W-1:0]       rpl_kind;
    logic [vr_msg_pkg::VIEW_W-1:0]       rpl_view;
    logic [vr_log_pkg::OP_W-1:0]         rpl_num;
    logic [vr_log_pkg::ENTRY_W-1:0]      rpl_data;
    logic                                full;

    vr_ctrl u_ctrl (
         .clk        (clk        )
        ,.rst_n      (rst_n      )
        ,.in_val     (in_val     )
        ,.in_msg     (in_msg     )
        ,.in_rdy     (in_rdy     )
        ,.wr_en      (wr_en      )
        ,.wr_addr    (wr_addr    )
        ,.wr_data    (wr_data    )
        ,.walk_start (walk_start )
        ,.walk_first (walk_first )
        ,.walk_count (walk_count )
        ,.walk_done  (walk_done  )
        ,.walk_sum   (walk_sum   )
        ,.push       (push       )
        ,.rpl_kind   (rpl_kind   )
        ,.rpl_view   (rpl_view   )
        ,.rpl_num    (rpl_num    )
        ,.rpl_data   (rpl_data   )
        ,.full       (full       )
    );

    vr_log_mem u_log_mem (
         .clk     (clk     )
        ,.wr_en   (wr_en   )
        ,.wr_addr (wr_addr )
        ,.wr_data (wr_data )
        ,.rd_en   (rd_en   )
        ,.rd_addr (rd_addr )
        ,.rd_data (rd_data )
    );

    vr_commit_walker u_walker (
         .clk        (clk        )
        ,.rst_n      (rst_n      )
        ,.walk_start (walk_start )
        ,.walk_first (walk_first )
        ,.walk_count (walk_count )
        ,.walk_done  (walk_done  )
        ,.walk_sum   (walk_sum   )
        ,.rd_en      (rd_en      )
        ,.rd_addr    (rd_addr    )
        ,.rd_data    (rd_data    )
    );

    vr_reply_queue u_reply_queue (
         .clk       (clk       )
        ,.rst_n     (rst_n     )
        ,.push      (push      )
        ,.rpl_kind  (rpl_kind  )
        ,.rpl_view  (rpl_view  )
        ,.rpl_num   (rpl_num   )
        ,.rpl_data  (rpl_data  )
        ,.full      (full      )
        ,.out_val   (out_val   )
        ,.out_reply (out_reply )
        ,.out_rdy   (out_rdy   )
    );

endmodule

// ==== sim/vr_tb.sv ====
`timescale 1ns/10ps

module vr_tb;

    localparam int MAX_ROWS = 64;
    localparam int TIMEOUT  = 200;    // Cycles allowed for any single wait.

    logic                           clk;
    logic                           rst_n;
    logic                           in_val;
    vr_msg_pkg::vr_msg_u            in_msg;
    logic                           in_rdy;
    logic                           out_val;
    logic [vr_msg_pkg::MSG_W-1:0]   out_reply;
    logic                           out_rdy;

    // Each row of the stimulus table holds one message and its expected reply.
    vr_msg_pkg::vr_msg_u            row_msg  [MAX_ROWS];
    logic [vr_msg_pkg::TYPE_W-1:0]  row_kind [MAX_ROWS];
    logic [vr_msg_pkg::VIEW_W-1:0]  row_view [MAX_ROWS];
    logic [vr_log_pkg::OP_W-1:0]    row_num  [MAX_ROWS];
    logic [vr_log_pkg::ENTRY_W-1:0] row_data [MAX_ROWS];
    int                             num_rows;

    int                             pending [$];   // Rows accepted but not yet answered.
    int                             errors;
    int                             timeouts;
    bit                             aborted;

    vr_top dut (
         .clk       (clk       )
        ,.rst_n     (rst_n     )
        ,.in_val    (in_val    )
        ,.in_msg    (in_msg    )
        ,.in_rdy    (in_rdy    )
        ,.out_val   (out_val   )
        ,.out_reply (out_reply )
        ,.out_rdy   (out_rdy   )
    );

    always #50 clk = ~clk;

    function automatic vr_msg_pkg::vr_msg_u msg_word(
        input logic [vr_msg_pkg::TYPE_W-1:0]  mtype,
        input logic [vr_msg_pkg::VIEW_W-1:0]  view,
        input logic [vr_log_pkg::OP_W-1:0]    num,
        input logic [vr_log_pkg::ENTRY_W-1:0] low
    );
        vr_msg_pkg::vr_msg_u m;
        m = '0;
        if (mtype == vr_msg_pkg::MSG_COMMIT) begin
            m.commit.msg_type   = mtype;
            m.commit.view       = view;
            m.commit.commit_num = num;
            m.commit.rsvd       = low;
        end else begin
            m.prepare.msg_type = mtype;
            m.prepare.view     = view;
            m.prepare.op_num   = num;
            m.prepare.entry    = low;
        end
        return m;
    endfunction

    task automatic add_row(
        input vr_msg_pkg::vr_msg_u            msg,
        input logic [vr_msg_pkg::TYPE_W-1:0]  kind,
        input logic [vr_msg_pkg::VIEW_W-1:0]  view,
        input logic [vr_log_pkg::OP_W-1:0]    num,
        input logic [vr_log_pkg::ENTRY_W-1:0] data
    );
        row_msg[num_rows]  = msg;
        row_kind[num_rows] = kind;
        row_view[num_rows] = view;
        row_num[num_rows]  = num;
        row_data[num_rows] = data;
        num_rows++;
    endtask

    task automatic build_table();
        // Set view 5 and send a wrong view and a skipped op_num that must leave the state alone.
        add_row(msg_word(2'd0, 14'd5, 16'd0, 32'h0), 2'd0, 14'd5, 16'd0, 32'h0);
        add_row(msg_word(2'd1, 14'd5, 16'd1, 32'h0000_1001), 2'd1, 14'd5, 16'd1, 32'h0);
        add_row(msg_word(2'd1, 14'd6, 16'd2, 32'hDEAD_BEEF), 2'd3, 14'd5, 16'd1, 32'h0);
        add_row(msg_word(2'd1, 14'd5, 16'd3, 32'hDEAD_BEEF), 2'd3, 14'd5, 16'd1, 32'h0);
        add_row(msg_word(2'd1, 14'd5, 16'd2, 32'h0000_2002), 2'd1, 14'd5, 16'd2, 32'h0);
        add_row(msg_word(2'd2, 14'd5, 16'd2, 32'h0), 2'd2, 14'd5, 16'd2, 32'h0000_3003);
        // A new view starts over at op_num 1.
        add_row(msg_word(2'd0, 14'd9, 16'd0, 32'h0), 2'd0, 14'd9, 16'd0, 32'h0);
        add_row(msg_word(2'd1, 14'd9, 16'd1, 32'hA5A5_0001), 2'd1, 14'd9, 16'd1, 32'h0);
        add_row(msg_word(2'd1, 14'd9, 16'd2, 32'h5A5A_0010), 2'd1, 14'd9, 16'd2, 32'h0);
        add_row(msg_word(2'd1, 14'd9, 16'd3, 32'h0F0F_0100), 2'd1, 14'd9, 16'd3, 32'h0);
        add_row(msg_word(2'd2, 14'd9, 16'd3, 32'h0), 2'd2, 14'd9, 16'd3, 32'hF0F0_0111);
        add_row(msg_word(2'd2, 14'd9, 16'd3, 32'h0), 2'd3, 14'd9, 16'd3, 32'h0);
        // Fill the log with ops 4 to 19 whose entries are {op, ~op}.
        for (int op = 4; op <= 19; op++) begin
            add_row(msg_word(2'd1, 14'd9, 16'(op), {16'(op), ~16'(op)}),
                    2'd1, 14'd9, 16'(op), 32'h0);
        end
        add_row(msg_word(2'd1, 14'd9, 16'd20, 32'h0014_FFEB), 2'd3, 14'd9, 16'd19, 32'h0);
        add_row(msg_word(2'd2, 14'd9, 16'd4, 32'h0), 2'd2, 14'd9, 16'd4, 32'h0004_FFFB);
        add_row(msg_word(2'd1, 14'd9, 16'd20, 32'h0014_FFEB), 2'd1, 14'd9, 16'd20, 32'h0);
        // This commit covers ops 5 to 20. A stale slot 4 would flip bit 4 of both halves.
        add_row(msg_word(2'd2, 14'd9, 16'd20, 32'h0), 2'd2, 14'd9, 16'd20, 32'h0010_0010);
        add_row(msg_word(2'd2, 14'd8, 16'd20, 32'h0), 2'd3, 14'd9, 16'd20, 32'h0);
        add_row(msg_word(2'd3, 14'd9, 16'd21, 32'h0), 2'd3, 14'd9, 16'd20, 32'h0);
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_kind(input int row, input logic [vr_msg_pkg::TYPE_W-1:0] got,
                              input logic [vr_msg_pkg::TYPE_W-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("error: kind got %h expected %h (row %0d)", got, exp, row);
        end
    endtask

    task automatic check_view(input int row, input logic [vr_msg_pkg::VIEW_W-1:0] got,
                              input logic [vr_msg_pkg::VIEW_W-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("error: view got %h expected %h (row %0d)", got, exp, row);
        end
    endtask

    task automatic check_num(input int row, input logic [vr_log_pkg::OP_W-1:0] got,
                             input logic [vr_log_pkg::OP_W-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("error: num got %h expected %h (row %0d)", got, exp, row);
        end
    endtask

    task automatic check_data(input int row, input logic [vr_log_pkg::ENTRY_W-1:0] got,
                              input logic [vr_log_pkg::ENTRY_W-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("error: data got %h expected %h (row %0d)", got, exp, row);
        end
    endtask

    task automatic check_reply(input int row);
        check_kind(row, out_reply[vr_msg_pkg::RPL_KIND_LSB +: vr_msg_pkg::TYPE_W], row_kind[row]);
        check_view(row, out_reply[vr_msg_pkg::RPL_VIEW_LSB +: vr_msg_pkg::VIEW_W], row_view[row]);
        check_num(row, out_reply[vr_msg_pkg::RPL_NUM_LSB +: vr_log_pkg::OP_W], row_num[row]);
        check_data(row, out_reply[vr_msg_pkg::RPL_DATA_LSB +: vr_log_pkg::ENTRY_W],
                   row_data[row]);
    endtask

    task automatic send_messages();
        int cycles;
        for (int i = 0; i < num_rows && !aborted; i++) begin
            in_val = 1'b1;
            in_msg = row_msg[i];
            cycles = 0;
            while (!in_rdy && cycles < TIMEOUT && !aborted) begin
                @(posedge clk);
                #1;
                cycles++;
            end
            if (in_rdy) begin
                pending.push_back(i);   // The transfer happens on the coming edge.
                @(posedge clk);
                #1;
            end else if (!aborted) begin
                timeouts++;
                aborted = 1'b1;
                $display("Timed out waiting for in_rdy to accept message %0d.", i);
            end
            in_val = 1'b0;
        end
    endtask

    task automatic receive_replies();
        int cycles;
        int row;
        bit got;
        for (int n = 0; n < num_rows && !aborted; n++) begin
            cycles = 0;
            got    = 1'b0;
            while (!got && cycles < TIMEOUT && !aborted) begin
                @(posedge clk);
                #1;
                out_rdy = ($urandom % 3) == 0;   // The output is mostly stalled so the queue fills.
                got     = out_val && out_rdy;
                cycles++;
            end
            if (got) begin
                if (pending.size() == 0) begin
                    errors++;
                    $display("A reply came out while no message was waiting for one.");
                end else begin
                    row = pending.pop_front();
                    check_reply(row);
                end
            end else if (!aborted) begin
                timeouts++;
                aborted = 1'b1;
                $display("Timed out waiting for out_val with reply %0d.", n);
            end
        end
    endtask

    task automatic check_no_extra_reply();
        bit seen;
        seen    = 1'b0;
        out_rdy = 1'b1;
        repeat (20) begin
            @(posedge clk);
            #1;
            seen = seen || out_val;
        end
        if (seen || pending.size() != 0) begin
            errors++;
            $display("Replies and messages did not pair up one to one at the end of the run.");
        end
    endtask

    initial begin
        void'($urandom(38));
        clk      = 1'b0;
        rst_n    = 1'b0;
        in_val   = 1'b0;
        in_msg   = '0;
        out_rdy  = 1'b0;
        errors   = 0;
        timeouts = 0;
        aborted  = 1'b0;
        num_rows = 0;
        build_table();
        repeat (3) @(posedge clk);
        #1;
        check_flag("in_rdy", in_rdy, 1'b0);
        check_flag("out_val", out_val, 1'b0);
        rst_n = 1'b1;
        fork
            send_messages();
            receive_replies();
        join
        if (!aborted) begin
            check_no_extra_reply();
        end
        $display("Errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== src.f ====
verilog/vr_log_pkg.sv
verilog/vr_msg_pkg.sv
verilog/vr_ctrl.sv
verilog/vr_log_mem.sv
verilog/vr_commit_walker.sv
verilog/vr_reply_queue.sv
verilog/vr_top.sv
sim/vr_tb.sv

// ==== Makefile ====
# Verilator flow for the replica engine and its testbench.

VERILATOR ?= verilator
FILELIST  ?= src.f
TB_TOP    ?= vr_tb
RTL_TOP   ?= vr_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
FAIL_MSG  ?= CHECKS FAILED

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -Wno-fatal -f $(FILELIST) \
	    --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	    echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
